// File: Bender.yml
package:
  name: mini_core

sources:
  - verilog/isa_pkg.sv
  - verilog/datapath_pkg.sv
  - verilog/alu.sv
  - verilog/reg_file.sv
  - verilog/pc_counter.sv
  - verilog/exec_fsm.sv
  - verilog/mini_core.sv
  - target: simulation
    files:
      - sim/mini_core_checker.sv
      - sim/tb_mini_core.sv

// File: sim/mini_core_checker.sv
`timescale 1ns/1ps

module mini_core_checker
    import datapath_pkg::*;
(
    input logic clock,
    input logic arst_n,
    input logic busy,
    input logic wb_valid,
    input wb_t  wb,
    input logic exec_en,
    input pc_t  pc
);

    // writeback is a single cycle pulse
    assert property (@(posedge clock) disable iff (!arst_n) wb_valid |=> !wb_valid)
        else $error("wb_valid held high for two cycles");

    // still idle in the cycle after a writeback
    assert property (@(posedge clock) disable iff (!arst_n) wb_valid |=> !busy)
        else $error("busy high one cycle after writeback");

    assert property (@(posedge clock) disable iff (!arst_n) wb_valid |-> !$isunknown(wb))
        else $error("writeback carries unknown bits");

    // pc moves only after an execute cycle
    assert property (@(posedge clock) disable iff (!arst_n) !exec_en |=> $stable(pc))
        else $error("pc changed without an executed instruction");

endmodule

// File: sim/tb_mini_core.sv
`timescale 1ns/1ps

module tb_mini_core
    import isa_pkg::*;
    import datapath_pkg::*;
();

    typedef struct {
        instr_u instr;
        bit     has_wb;
        wb_t    wb;
        bit     flag;
        pc_t    pc;
        bit     stray;   // strobe again while busy
    } entry_t;

    logic   clock;
    logic   arst_n;
    logic   instr_valid;
    instr_u instr;
    logic   busy;
    logic   wb_valid;
    wb_t    wb;
    logic   flag;
    pc_t    pc;

    entry_t      table_q[$];
    word_t       model[nregs];   // expected register contents
    logic [31:0] lcg_state = 32'd79;
    int          n_entries = 0;

    mini_core i_mini_core (.*);

    bind mini_core mini_core_checker i_mini_core_checker (.*);

    initial
    begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic instr_u rform(opcode_t op, reg_idx_t rd, reg_idx_t ra, reg_idx_t rb);
        instr_u u;
        u          = '0;
        u.r.opcode = op;
        u.r.rd     = rd;
        u.r.ra     = ra;
        u.r.rb     = rb;
        return u;
    endfunction

    function automatic instr_u iform(opcode_t op, reg_idx_t rd, reg_idx_t ra, bit hl,
                                     logic [15:0] imm);
        instr_u u;
        u           = '0;
        u.i.opcode  = op;
        u.i.rd      = rd;
        u.i.ra      = ra;
        u.i.highlow = hl;
        u.i.imm     = imm;
        return u;
    endfunction

    function automatic void add_entry(instr_u ins, bit has_wb, word_t data, bit fl, pc_t p,
                                      bit stray = 1'b0);
        entry_t e;
        e.instr  = ins;
        e.has_wb = has_wb;
        e.wb     = '{rd: ins.r.rd, data: data};
        e.flag   = fl;
        e.pc     = p;
        e.stray  = stray;
        table_q.push_back(e);
        if (has_wb)
            model[ins.r.rd] = data;
    endfunction

    task automatic fail_run();
        $display("tests failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_wb(input wb_t got, input wb_t exp, input string what);
        if (got !== exp)
        begin
            $display("MISMATCH at %0t: %s wb rd %0d data %h, expected rd %0d data %h",
                     $time, what, got.rd, got.data, exp.rd, exp.data);
            fail_run();
        end
    endtask

    task automatic check_flag(input logic got, input bit exp, input string what);
        if (got !== exp)
        begin
            $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
            fail_run();
        end
    endtask

    task automatic check_pc(input pc_t got, input pc_t exp, input string what);
        if (got !== exp)
        begin
            $display("MISMATCH at %0t: %s pc %h, expected %h", $time, what, got, exp);
            fail_run();
        end
    endtask

    task automatic run_entry(input entry_t e, input string what);
        int cycles;
        while (busy)
            @(negedge clock);
        instr_valid = 1'b1;
        instr       = e.instr;
        @(negedge clock);
        if (!busy)
        begin
            $display("%s: instruction was not accepted while the core was idle", what);
            fail_run();
        end
        if (e.stray)
            instr = rform(op_add, 14, 1, 1);   // must be dropped
        else
            instr_valid = 1'b0;
        cycles = 1;
        while (busy)
        begin
            @(negedge clock);
            cycles++;
        end
        instr_valid = 1'b0;
        if (cycles != 3)
        begin
            $display("MISMATCH at %0t: %s took %0d cycles, expected 3", $time, what, cycles);
            fail_run();
        end
        check_flag(wb_valid, e.has_wb, {what, " wb_valid"});
        if (e.has_wb)
            check_wb(wb, e.wb, what);
        check_flag(flag, e.flag, {what, " flag"});
        check_pc(pc, e.pc, what);
        @(negedge clock);   // pulse over, nothing else retired
        check_flag(wb_valid, 1'b0, {what, " wb_valid after pulse"});
        check_flag(busy, 1'b0, {what, " busy after retire"});
        check_pc(pc, e.pc, {what, " after retire"});
    endtask

    initial
    begin
        logic [31:0] r;
        opcode_t     op;
        reg_idx_t    rd;
        reg_idx_t    ra;
        reg_idx_t    rb;
        word_t       res;
        instr_valid = 1'b0;
        instr       = '0;
        arst_n      = 1'b0;
        for (int i = 0; i < nregs; i++)
            model[i] = '0;

        add_entry(iform(op_ldh, 1, 0, 1'b1, 16'h1234), 1, 32'h1234_0000, 0, 1);
        add_entry(iform(op_ldh_alt, 1, 1, 1'b0, 16'h5678), 1, 32'h1234_5678, 0, 2);
        add_entry(iform(op_ldh, 2, 0, 1'b1, 16'hf000), 1, 32'hf000_0000, 0, 3);
        add_entry(rform(op_add, 3, 1, 2), 1, 32'h0234_5678, 0, 4);   // wraps
        add_entry(rform(op_sub, 4, 0, 1), 1, 32'hedcb_a988, 0, 5);
        add_entry(iform(op_ldh, 6, 0, 1'b0, 16'h0001), 1, 32'h0000_0001, 0, 6);
        add_entry(iform(op_ldh_alt, 7, 0, 1'b0, 16'h001f), 1, 32'h0000_001f, 0, 7);
        add_entry(rform(op_shl, 9, 1, 0), 1, 32'h1234_5678, 0, 8);
        add_entry(rform(op_shl, 9, 1, 6), 1, 32'h2468_acf1, 0, 9);
        add_entry(rform(op_shl, 9, 1, 7), 1, 32'h7fff_ffff, 0, 10);
        add_entry(rform(op_shr, 9, 1, 0), 1, 32'h1234_5678, 0, 11);
        add_entry(rform(op_shr, 9, 1, 6), 1, 32'h891a_2b3c, 0, 12);
        add_entry(rform(op_shr, 9, 1, 7), 1, 32'hffff_fffe, 0, 13);
        add_entry(rform(op_mov, 10, 4, 0), 1, 32'hedcb_a988, 0, 14, 1'b1);
        add_entry(rform(op_mov_alt, 11, 3, 0), 1, 32'h0234_5678, 0, 15);
        add_entry(rform(op_ceq, 0, 1, 1), 0, '0, 1, 16);
        add_entry(rform(op_clt, 0, 1, 2), 0, '0, 1, 17);   // unsigned
        add_entry(rform(op_cgt, 0, 1, 2), 0, '0, 0, 18);
        add_entry(iform(op_ldh, 8, 0, 1'b0, 16'h0100), 1, 32'h0000_0100, 0, 19);
        add_entry(rform(op_jf, 0, 0, 0), 0, '0, 0, 20);
        add_entry(rform(op_fnot, 0, 0, 0), 0, '0, 1, 21);
        add_entry(rform(op_jf, 0, 0, 0), 0, '0, 1, 32'h100);
        add_entry(rform(op_ceq, 0, 1, 2), 0, '0, 0, 32'h101);
        add_entry(rform(op_jmp, 0, 0, 0), 0, '0, 0, 32'h100, 1'b1);
        add_entry(rform(opcode_t'(6'd12), 5, 1, 1), 0, '0, 0, 32'h101);

        for (int i = 0; i < 40; i++)
        begin
            r   = lcg_next();
            rd  = r[19:16];
            ra  = r[23:20];
            rb  = r[27:24];
            op  = r[30] ? op_sub : op_add;
            res = (op == op_sub) ? model[ra] - model[rb] : model[ra] + model[rb];
            add_entry(rform(op, rd, ra, rb), 1, res, 0, 32'h102 + i);
        end
        n_entries = table_q.size();

        repeat (10)
            @(posedge clock);
        @(negedge clock);
        arst_n = 1'b1;
        check_flag(busy, 1'b0, "busy after reset");
        check_flag(wb_valid, 1'b0, "wb_valid after reset");
        check_flag(flag, 1'b0, "flag after reset");
        check_pc(pc, '0, "reset");

        foreach (table_q[i])
            run_entry(table_q[i], $sformatf("entry %0d", i));

        $display("all tests passed");
        $finish;
    end

    initial
    begin
        wait (n_entries > 0);
        repeat (n_entries * 8 + 100)
            @(posedge clock);
        $display("timeout: the core did not finish the instruction table in time");
        fail_run();
    end

endmodule

// File: sources.f
verilog/isa_pkg.sv
verilog/datapath_pkg.sv
verilog/alu.sv
verilog/reg_file.sv
verilog/pc_counter.sv
verilog/exec_fsm.sv
verilog/mini_core.sv
sim/mini_core_checker.sv
sim/tb_mini_core.sv

// File: verilog/alu.sv
`timescale 1ns/1ps

module alu
    import isa_pkg::*;
    import datapath_pkg::*;
(
    input  instr_u   instr,
    input  word_t    a,
    input  word_t    b,
    input  word_t    link,
    input  logic     flag,
    output alu_out_t alu_out
);

    opcode_t    op;
    logic [4:0] shamt;
    word_t      half_load;

    assign op    = instr.r.opcode;
    assign shamt = b[4:0];   // only low five bits count

    // replace one half of a with the immediate
    assign half_load = instr.i.highlow ? {instr.i.imm, a[data_w/2-1:0]}
                                       : {a[data_w-1:data_w/2], instr.i.imm};

    always_comb
    begin
        alu_out = '0;
        case (op)
            op_add:
            begin
                alu_out.result = a + b;
                alu_out.wr_en  = 1'b1;
            end
            op_sub:
            begin
                alu_out.result = a - b;
                alu_out.wr_en  = 1'b1;
            end
            op_shl:
            begin
                alu_out.result = ~(~a << shamt);   // ones shifted in
                alu_out.wr_en  = 1'b1;
            end
            op_shr:
            begin
                alu_out.result = ~(~a >> shamt);
                alu_out.wr_en  = 1'b1;
            end
            op_mov, op_mov_alt:
            begin
                alu_out.result = a;
                alu_out.wr_en  = 1'b1;
            end
            op_ldh, op_ldh_alt:
            begin
                alu_out.result = half_load;
                alu_out.wr_en  = 1'b1;
            end
            op_ceq:
            begin
                alu_out.flag_en   = 1'b1;
                alu_out.flag_next = (a == b);
            end
            op_clt:
            begin
                alu_out.flag_en   = 1'b1;
                alu_out.flag_next = (a < b);   // unsigned
            end
            op_cgt:
            begin
                alu_out.flag_en   = 1'b1;
                alu_out.flag_next = (a > b);
            end
            op_fnot:
            begin
                alu_out.flag_en   = 1'b1;
                alu_out.flag_next = ~flag;
            end
            op_jmp:
            begin
                alu_out.result      = link;
                alu_out.take_branch = 1'b1;
            end
            op_jf:
            begin
                alu_out.result      = link;
                alu_out.take_branch = flag;   // else just step
            end
            default:
            begin
                alu_out = '0;   // nop
            end
        endcase
    end

endmodule

// File: verilog/datapath_pkg.sv
package datapath_pkg;

    localparam int unsigned data_w    = 32;
    localparam int unsigned reg_idx_w = 4;
    localparam int unsigned nregs     = 1 << reg_idx_w;

    typedef logic [data_w-1:0]    word_t;
    typedef logic [reg_idx_w-1:0] reg_idx_t;
    typedef logic [31:0]          pc_t;

    // writeback beat
    typedef struct packed {
        reg_idx_t rd;
        word_t    data;
    } wb_t;

    typedef struct packed {
        word_t result;        // also carries the branch target
        logic  wr_en;
        logic  flag_en;
        logic  flag_next;
        logic  take_branch;
    } alu_out_t;

endpackage

// File: verilog/exec_fsm.sv
`timescale 1ns/1ps

module exec_fsm
    import isa_pkg::*;
(
    input  logic   clock,
    input  logic   arst_n,
    input  logic   instr_valid,
    input  instr_u instr,
    input  logic   flag_en,
    input  logic   flag_next,
    output logic   busy,
    output logic   read_en,
    output logic   exec_en,
    output logic   flag,
    output instr_u cur_instr
);

    typedef enum logic [1:0] {
        s_idle,
        s_read,
        s_exec
    } state_t;

    state_t state;
    state_t state_next;
    logic   accept;

    assign accept = instr_valid && (state == s_idle);   // strobes while busy drop

    always_comb
    begin
        state_next = state;
        case (state)
            s_idle:
                if (accept)
                    state_next = s_read;
            s_read:
                state_next = s_exec;
            s_exec:
                state_next = s_idle;
            default:
                state_next = s_idle;
        endcase
    end

    always_ff @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
            state <= s_idle;
        else
            state <= state_next;
    end

    always_ff @(posedge clock)
    begin
        if (accept)
            cur_instr <= instr;
    end

    // compare flag
    always_ff @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
            flag <= 1'b0;
        else if (exec_en && flag_en)
            flag <= flag_next;
    end

    assign busy    = (state != s_idle);
    assign read_en = (state == s_read);
    assign exec_en = (state == s_exec);

endmodule

// File: verilog/isa_pkg.sv
package isa_pkg;

    // branch target register
    localparam int unsigned link_reg = 8;

    typedef enum logic [5:0] {
        op_add     = 6'd0,
        op_sub     = 6'd1,
        op_shl     = 6'd2,   // fills with ones
        op_shr     = 6'd3,   // fills with ones
        op_mov     = 6'd4,
        op_ldh     = 6'd5,
        op_ldh_alt = 6'd6,
        op_mov_alt = 6'd7,
        op_ceq     = 6'd8,
        op_clt     = 6'd9,
        op_cgt     = 6'd10,
        op_fnot    = 6'd11,
        op_jmp     = 6'd14,
        op_jf      = 6'd15
    } opcode_t;

    // register form
    typedef struct packed {
        opcode_t     opcode;
        logic [3:0]  rd;
        logic [3:0]  ra;
        logic [3:0]  rb;
        logic [13:0] unused;
    } instr_reg_t;

    // immediate form, rd and ra in the same place as above
    typedef struct packed {
        opcode_t     opcode;
        logic [3:0]  rd;
        logic [3:0]  ra;
        logic        highlow;   // 1 = upper half
        logic        pad;
        logic [15:0] imm;
    } instr_imm_t;

    typedef union packed {
        instr_reg_t r;
        instr_imm_t i;
    } instr_u;

endpackage

// File: verilog/mini_core.sv
`timescale 1ns/1ps

module mini_core
    import isa_pkg::*;
    import datapath_pkg::*;
(
    input  logic   clock,
    input  logic   arst_n,
    input  logic   instr_valid,
    input  instr_u instr,
    output logic   busy,
    output logic   wb_valid,
    output wb_t    wb,
    output logic   flag,
    output pc_t    pc
);

    logic     read_en;
    logic     exec_en;
    instr_u   cur_instr;
    word_t    rdata_a;
    word_t    rdata_b;
    word_t    link;
    alu_out_t alu_out;
    logic     reg_we;

    assign reg_we = exec_en && alu_out.wr_en;

    exec_fsm i_exec_fsm (
        .clock       (clock),
        .arst_n      (arst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .flag_en     (alu_out.flag_en),
        .flag_next   (alu_out.flag_next),
        .busy        (busy),
        .read_en     (read_en),
        .exec_en     (exec_en),
        .flag        (flag),
        .cur_instr   (cur_instr)
    );

    reg_file i_reg_file (
        .clock   (clock),
        .arst_n  (arst_n),
        .read_en (read_en),
        .ra      (cur_instr.r.ra),
        .rb      (cur_instr.r.rb),
        .we      (reg_we),
        .wa      (cur_instr.r.rd),
        .wdata   (alu_out.result),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b),
        .link    (link)
    );

    alu i_alu (
        .instr   (cur_instr),
        .a       (rdata_a),
        .b       (rdata_b),
        .link    (link),
        .flag    (flag),
        .alu_out (alu_out)
    );

    // target is register 8, passed through the alu result
    pc_counter i_pc_counter (
        .clock  (clock),
        .arst_n (arst_n),
        .step   (exec_en),
        .load   (alu_out.take_branch),
        .target (alu_out.result),
        .pc     (pc)
    );

    always_ff @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
            wb_valid <= 1'b0;
        else
            wb_valid <= reg_we;   // one cycle pulse
    end

    always_ff @(posedge clock)
    begin
        if (reg_we)
            wb <= '{rd: cur_instr.r.rd, data: alu_out.result};
    end

endmodule

// File: verilog/pc_counter.sv
`timescale 1ns/1ps

module pc_counter
    import datapath_pkg::*;
(
    input  logic clock,
    input  logic arst_n,
    input  logic step,     // one pulse per retired instruction
    input  logic load,
    input  pc_t  target,
    output pc_t  pc
);

    pc_t pc_q;

    always_ff @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
            pc_q <= '0;
        else if (step)
        begin
            if (load)
                pc_q <= target;   // taken branch
            else
                pc_q <= pc_q + 32'd1;
        end
    end

    assign pc = pc_q;

endmodule

// File: verilog/reg_file.sv
`timescale 1ns/1ps

module reg_file
    import isa_pkg::*;
    import datapath_pkg::*;
(
    input  logic     clock,
    input  logic     arst_n,
    input  logic     read_en,
    input  reg_idx_t ra,
    input  reg_idx_t rb,
    input  logic     we,
    input  reg_idx_t wa,
    input  word_t    wdata,
    output word_t    rdata_a,
    output word_t    rdata_b,
    output word_t    link
);

    word_t regs [nregs];

    always_ff @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < nregs; i++)
                regs[i] <= '0;
        end
        else if (we)
            regs[wa] <= wdata;
    end

    // operand registers, loaded once per instruction
    always_ff @(posedge clock)
    begin
        if (read_en)
        begin
            rdata_a <= regs[ra];
            rdata_b <= regs[rb];
        end
    end

    assign link = regs[link_reg];

endmodule
